/* attr_conv.f */
+incdir+logic
logic/float_pkg.sv
logic/fragment_pkg.sv
logic/value_delay.sv
logic/float_to_fixed.sv
logic/attribute_f2x_converter.sv
tests/tb_attribute_f2x.sv

/* build_sim.sh */
#!/bin/sh
# Compile and run the attribute conversion testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=$BUILD_DIR/sim.log

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing -f attr_conv.f --top-module tb_attribute_f2x \
    -Mdir "$BUILD_DIR/obj" -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$BUILD_DIR/obj/tb_sim" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "sim failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* logic/attr_conv_params.svh */
/*
 * Attribute conversion widths
 * Widths and fraction bit counts of the fragment stream
 */
`ifndef ATTR_CONV_PARAMS_SVH
`define ATTR_CONV_PARAMS_SVH

// Screen x/y coordinate
`define ATTR_SCREEN_POS_WIDTH 11

// Framebuffer index
`define ATTR_INDEX_WIDTH 32

// Colour channel after clamping
`define ATTR_SUB_PIXEL_WIDTH 8

// Fraction bits, depth z is Q16.16 and texture coords S16.15
`define ATTR_DEPTH_WIDTH 16
`define ATTR_TEX_FRAC_BITS 15

`endif

/* logic/attribute_f2x_converter.sv */
/*
 * Attribute float to fixed-point conversion stage
 * Converts depth z, texture coordinates and colours of each fragment
 * and delays the pass-through fields to match, two cycles in total
 */
`include "attr_conv_params.svh"

module attribute_f2x_converter #(
    parameter bit ENABLE_LOD_CALC = 1
)
(
    input  logic                            aclk,
    input  logic                            reset,

    // Fragment from the interpolator
    input  logic                            valid,
    input  logic                            last,
    input  logic                            keep,
    input  fragment_pkg::screen_pos_t       spx,
    input  fragment_pkg::screen_pos_t       spy,
    input  logic [`ATTR_INDEX_WIDTH-1:0]    index,
    input  logic [31:0]                     depth_w,
    input  logic [31:0]                     depth_z,
    input  logic [31:0]                     texture_s,
    input  logic [31:0]                     texture_t,
    input  logic [31:0]                     mipmap_s,
    input  logic [31:0]                     mipmap_t,
    input  logic [31:0]                     color_r,
    input  logic [31:0]                     color_g,
    input  logic [31:0]                     color_b,
    input  logic [31:0]                     color_a,

    // Fragment to the pixel pipeline
    output logic                            out_valid,
    output logic                            out_last,
    output logic                            out_keep,
    output fragment_pkg::screen_pos_t       out_spx,
    output fragment_pkg::screen_pos_t       out_spy,
    output logic [`ATTR_INDEX_WIDTH-1:0]    out_index,
    output logic [31:0]                     out_depth_w,    // still float
    output fragment_pkg::fixed_t            out_depth_z,    // Q16.16
    output fragment_pkg::fixed_t            out_texture_s,  // S16.15
    output fragment_pkg::fixed_t            out_texture_t,
    output fragment_pkg::fixed_t            out_mipmap_s,
    output fragment_pkg::fixed_t            out_mipmap_t,
    output fragment_pkg::color_t            out_color_r,
    output fragment_pkg::color_t            out_color_g,
    output fragment_pkg::color_t            out_color_b,
    output fragment_pkg::color_t            out_color_a
);

    localparam int CONV_DELAY = 2;
    localparam int CF         = fragment_pkg::COLOR_FRAC_BITS;

    // Anything at or above 1.0, or negative, becomes full intensity
    function automatic fragment_pkg::color_t clamp_color(input fragment_pkg::fixed_t v);
        if (|v[fragment_pkg::FIXED_WIDTH-1:CF])
        begin
            return '1;
        end
        return v[CF-1 -: `ATTR_SUB_PIXEL_WIDTH];
    endfunction

    //////////////////////////////
    // Conversion, 2 cycles
    //////////////////////////////
    logic                           conv_valid;
    logic                           conv_last;
    logic                           conv_keep;
    fragment_pkg::screen_pos_t      conv_spx;
    fragment_pkg::screen_pos_t      conv_spy;
    logic [`ATTR_INDEX_WIDTH-1:0]   conv_index;
    logic [31:0]                    conv_depth_w;
    fragment_pkg::fixed_t           conv_depth_z;
    fragment_pkg::fixed_t           conv_texture_s;
    fragment_pkg::fixed_t           conv_texture_t;
    fragment_pkg::fixed_t           conv_mipmap_s;
    fragment_pkg::fixed_t           conv_mipmap_t;
    fragment_pkg::fixed_t           conv_color_r;
    fragment_pkg::fixed_t           conv_color_g;
    fragment_pkg::fixed_t           conv_color_b;
    fragment_pkg::fixed_t           conv_color_a;

    // Stream flags, valid and last must come up clean after reset
    value_delay #(.WIDTH(1), .DELAY(CONV_DELAY), .RESETTABLE(1))
        i_valid_delay (.aclk(aclk), .reset(reset), .in(valid), .out(conv_valid));
    value_delay #(.WIDTH(1), .DELAY(CONV_DELAY), .RESETTABLE(1))
        i_last_delay (.aclk(aclk), .reset(reset), .in(last), .out(conv_last));
    value_delay #(.WIDTH(1), .DELAY(CONV_DELAY), .RESETTABLE(0))
        i_keep_delay (.aclk(aclk), .reset(reset), .in(keep), .out(conv_keep));

    // Position, index and depth w pass through untouched
    value_delay #(.WIDTH(`ATTR_SCREEN_POS_WIDTH), .DELAY(CONV_DELAY), .RESETTABLE(0))
        i_spx_delay (.aclk(aclk), .reset(reset), .in(spx), .out(conv_spx));
    value_delay #(.WIDTH(`ATTR_SCREEN_POS_WIDTH), .DELAY(CONV_DELAY), .RESETTABLE(0))
        i_spy_delay (.aclk(aclk), .reset(reset), .in(spy), .out(conv_spy));
    value_delay #(.WIDTH(`ATTR_INDEX_WIDTH), .DELAY(CONV_DELAY), .RESETTABLE(0))
        i_index_delay (.aclk(aclk), .reset(reset), .in(index), .out(conv_index));
    value_delay #(.WIDTH(32), .DELAY(CONV_DELAY), .RESETTABLE(0))
        i_depth_w_delay (.aclk(aclk), .reset(reset), .in(depth_w), .out(conv_depth_w));

    // Depth z
    float_to_fixed #(.FRAC_BITS(`ATTR_DEPTH_WIDTH))
        i_depth_z_conv (.aclk(aclk), .in(depth_z), .out(conv_depth_z));

    // Texture coordinates
    float_to_fixed #(.FRAC_BITS(`ATTR_TEX_FRAC_BITS))
        i_texture_s_conv (.aclk(aclk), .in(texture_s), .out(conv_texture_s));
    float_to_fixed #(.FRAC_BITS(`ATTR_TEX_FRAC_BITS))
        i_texture_t_conv (.aclk(aclk), .in(texture_t), .out(conv_texture_t));

    // Mipmap coordinates only exist with LOD calculation
    generate
        if (ENABLE_LOD_CALC)
        begin : g_lod
            float_to_fixed #(.FRAC_BITS(`ATTR_TEX_FRAC_BITS))
                i_mipmap_s_conv (.aclk(aclk), .in(mipmap_s), .out(conv_mipmap_s));
            float_to_fixed #(.FRAC_BITS(`ATTR_TEX_FRAC_BITS))
                i_mipmap_t_conv (.aclk(aclk), .in(mipmap_t), .out(conv_mipmap_t));
        end
        else
        begin : g_no_lod
            assign conv_mipmap_s = conv_texture_s;
            assign conv_mipmap_t = conv_texture_t;
        end
    endgenerate

    // Colour channels
    float_to_fixed #(.FRAC_BITS(CF))
        i_color_r_conv (.aclk(aclk), .in(color_r), .out(conv_color_r));
    float_to_fixed #(.FRAC_BITS(CF))
        i_color_g_conv (.aclk(aclk), .in(color_g), .out(conv_color_g));
    float_to_fixed #(.FRAC_BITS(CF))
        i_color_b_conv (.aclk(aclk), .in(color_b), .out(conv_color_b));
    float_to_fixed #(.FRAC_BITS(CF))
        i_color_a_conv (.aclk(aclk), .in(color_a), .out(conv_color_a));

    //////////////////////////////
    // Output, 0 cycles
    //////////////////////////////
    assign out_valid     = conv_valid;
    assign out_last      = conv_last;
    assign out_keep      = conv_keep;
    assign out_spx       = conv_spx;
    assign out_spy       = conv_spy;
    assign out_index     = conv_index;
    assign out_depth_w   = conv_depth_w;
    assign out_depth_z   = conv_depth_z;
    assign out_texture_s = conv_texture_s;
    assign out_texture_t = conv_texture_t;
    assign out_mipmap_s  = conv_mipmap_s;
    assign out_mipmap_t  = conv_mipmap_t;

    // Colour clamp
    assign out_color_r = clamp_color(conv_color_r);
    assign out_color_g = clamp_color(conv_color_g);
    assign out_color_b = clamp_color(conv_color_b);
    assign out_color_a = clamp_color(conv_color_a);

endmodule

/* logic/float_pkg.sv */
/*
 * Single-precision float word
 * Field layout of an IEEE 754 binary32 value and its raw/decoded views
 */
package float_pkg;

    // Field widths of binary32
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 23;

    // Exponent bias
    localparam int EXP_BIAS = 127;

    // Decoded view, sign in the top bit
    typedef struct packed {
        logic                    sign;
        logic [EXP_WIDTH-1:0]    exponent;
        logic [MANT_WIDTH-1:0]   mantissa;
    } float_fields_t;

    // Same 32 bits, seen either as a plain word or as fields
    typedef union packed {
        logic [31:0]     raw;
        float_fields_t   fields;
    } float_word_t;

endpackage

/* logic/float_to_fixed.sv */
/*
 * Float to fixed-point converter
 * Two-stage pipeline from binary32 to a signed fixed-point word with
 * FRAC_BITS fraction bits, truncating toward zero and saturating
 */
module float_to_fixed #(
    parameter int FRAC_BITS = 16
)
(
    input  logic                    aclk,
    input  float_pkg::float_word_t  in,
    output fragment_pkg::fixed_t    out
);

    // Magnitude bits below the sign of the result
    localparam int MAG_WIDTH = fragment_pkg::FIXED_WIDTH - 1;

    // Free bits above the hidden bit when the mantissa sits left aligned
    localparam int HEADROOM = MAG_WIDTH - float_pkg::MANT_WIDTH - 1;

    // Right shift of the left aligned mantissa for a zero exponent field
    localparam int SHIFT_BASE =
        float_pkg::EXP_BIAS + float_pkg::MANT_WIDTH + HEADROOM - FRAC_BITS;

    localparam int DIST_WIDTH  = 10;
    localparam int SHIFT_WIDTH = DIST_WIDTH - 1;

    //////////////////////////////
    // Stage one
    // Decode and shift distance
    //////////////////////////////
    logic signed [DIST_WIDTH-1:0]       s0_dist;

    logic                               s1_sign;
    logic [float_pkg::MANT_WIDTH-1:0]   s1_mant;
    logic                               s1_zero;
    logic                               s1_ovf;
    logic [SHIFT_WIDTH-1:0]             s1_shift;

    // Negative distance means the value needs more than MAG_WIDTH bits
    assign s0_dist = DIST_WIDTH'(SHIFT_BASE)
        - $signed({{(DIST_WIDTH - float_pkg::EXP_WIDTH){1'b0}}, in.fields.exponent});

    always_ff @(posedge aclk)
    begin
        s1_sign  <= in.fields.sign;
        s1_mant  <= in.fields.mantissa;
        // Zero and denormals
        s1_zero  <= (in.fields.exponent == '0);
        // Also catches infinity and NaN
        s1_ovf   <= s0_dist[DIST_WIDTH-1];
        s1_shift <= s0_dist[SHIFT_WIDTH-1:0];
    end

    //////////////////////////////
    // Stage two
    // Shift, sign and saturate
    //////////////////////////////
    logic [MAG_WIDTH-1:0]   s1_mag;
    fragment_pkg::fixed_t   s1_fixed;

    // Hidden bit restored, large shifts drain to zero
    assign s1_mag   = {1'b1, s1_mant, {HEADROOM{1'b0}}} >> s1_shift;
    assign s1_fixed = {1'b0, s1_mag};

    always_ff @(posedge aclk)
    begin
        if (s1_zero)
        begin
            out <= '0;
        end
        else if (s1_ovf)
        begin
            out <= s1_sign ? fragment_pkg::FIXED_MIN : fragment_pkg::FIXED_MAX;
        end
        else if (s1_sign)
        begin
            out <= -s1_fixed;
        end
        else
        begin
            out <= s1_fixed;
        end
    end

endmodule

/* logic/fragment_pkg.sv */
/*
 * Fragment stream types
 * Fixed-point words, screen position and colour channel of a fragment
 */
`include "attr_conv_params.svh"

package fragment_pkg;

    // Width of every converted attribute word
    localparam int FIXED_WIDTH = 32;

    // Colours are converted with 16 fraction bits before clamping
    localparam int COLOR_FRAC_BITS = 16;

    // Two's complement fixed-point value, binary point set per attribute
    typedef logic signed [FIXED_WIDTH-1:0] fixed_t;

    // Saturation limits
    localparam fixed_t FIXED_MAX = {1'b0, {(FIXED_WIDTH - 1){1'b1}}};
    localparam fixed_t FIXED_MIN = {1'b1, {(FIXED_WIDTH - 1){1'b0}}};

    // Unsigned screen coordinate
    typedef logic [`ATTR_SCREEN_POS_WIDTH-1:0] screen_pos_t;

    // Unsigned colour fraction, all ones means 1.0
    typedef logic [`ATTR_SUB_PIXEL_WIDTH-1:0] color_t;

endpackage

/* logic/value_delay.sv */
/*
 * Value delay line
 * Shifts a value through DELAY register stages, optionally cleared on reset
 */
module value_delay #(
    parameter int WIDTH      = 1,
    parameter int DELAY      = 1,
    parameter bit RESETTABLE = 0
)
(
    input  logic               aclk,
    input  logic               reset,
    input  logic [WIDTH-1:0]   in,
    output logic [WIDTH-1:0]   out
);

    generate
        if (DELAY == 0)
        begin : g_bypass
            assign out = in;
        end
        else
        begin : g_stages
            logic [WIDTH-1:0] stages [DELAY];

            always_ff @(posedge aclk)
            begin
                // Only the resettable variant clears its stages
                if (RESETTABLE && reset)
                begin
                    stages <= '{default: '0};
                end
                else
                begin
                    stages[0] <= in;
                    for (int i = 1; i < DELAY; i++)
                    begin
                        stages[i] <= stages[i - 1];
                    end
                end
            end

            assign out = stages[DELAY - 1];
        end
    endgenerate

endmodule

/* tests/attribute_testdata.hex */
// hdr(test[31:24] last[23] keep[22] spx[21:11] spy[10:0]) index depth_w z ts tt ms mt r g b a
// then expected: z ts tt ms mt rgba(r[31:24] g b a)
01400802 00000000 3F800000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
013FFFFF FFFFFFFF BF000000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
01CAAAAA 12345678 42C80000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
01800000 A5A5A5A5 7F800000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
01600001 0000FFFF 00000001 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
01C01804 89ABCDEF C0700000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
02400001 00000201 3F800000 00000000 3F800000 BF000000 40200000 C0700000 00000000 00000000 00000000 00000000 00000000 00008000 FFFFC000 00014000 FFFE2000 00000000
02400002 00000202 3F000000 00000000 3DCCCCCD BDCCCCCD 42C80000 3FC00000 00000000 00000000 00000000 00000000 00000000 00000CCC FFFFF334 00320000 0000C000 00000000
02400003 00000203 40200000 00000000 00000000 80000000 00000001 807FFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
02400004 00000204 3E800000 00000000 358637BD 3F400000 C2C80000 3E800000 00000000 00000000 00000000 00000000 00000000 00000000 00006000 FFCE0000 00002000 00000000
02400005 00000205 42C80000 00000000 46800000 47800000 C7800000 47000000 00000000 00000000 00000000 00000000 00000000 20000000 7FFFFFFF 80000000 40000000 00000000
02C00006 00000206 3F800000 00000000 40400000 C0200000 3F000000 BF800000 00000000 00000000 00000000 00000000 00000000 00018000 FFFEC000 00004000 FFFF8000 00000000
03400001 00000301 3F800000 3F000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00008000 00000000 00000000 00000000 00000000 00000000
03400002 00000302 3F800000 C0700000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFC4000 00000000 00000000 00000000 00000000 00000000
03400003 00000303 3F800000 46800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 40000000 00000000 00000000 00000000 00000000 00000000
03400004 00000304 3F800000 C6800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 C0000000 00000000 00000000 00000000 00000000 00000000
03400005 00000305 3F800000 501502F9 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFF 00000000 00000000 00000000 00000000 00000000
03400006 00000306 3F800000 FF800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000000 00000000 00000000 00000000 00000000 00000000
03400007 00000307 3F800000 47000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFF 00000000 00000000 00000000 00000000 00000000
03400008 00000308 3F800000 7FC00000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFF 00000000 00000000 00000000 00000000 00000000
03C00009 00000309 3F800000 3DCCCCCD 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00001999 00000000 00000000 00000000 00000000 00000000
04400001 00000401 40000000 00000000 00000000 00000000 00000000 00000000 3F000000 3E800000 3F400000 3F800000 00000000 00000000 00000000 00000000 00000000 8040C0FF
04400002 00000402 40000000 00000000 00000000 00000000 00000000 00000000 3F19999A 3DCCCCCD 3F7F0000 00000000 00000000 00000000 00000000 00000000 00000000 9919FF00
04400003 00000403 40000000 00000000 00000000 00000000 00000000 00000000 40000000 42C80000 BF000000 BDCCCCCD 00000000 00000000 00000000 00000000 00000000 FFFFFFFF
04400004 00000404 40000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 80000000 358637BD 00000000 00000000 00000000 00000000 00000000 00000000
04400005 00000405 40000000 00000000 00000000 00000000 00000000 00000000 7F800000 FF800000 7FC00000 3E800000 00000000 00000000 00000000 00000000 00000000 FFFFFF40
04C00006 00000406 40000000 00000000 00000000 00000000 00000000 00000000 3B800000 3B000000 3F7FFFFF 3F800000 00000000 00000000 00000000 00000000 00000000 0100FFFF
05400010 00000501 3F800000 3F000000 3F800000 40200000 3E800000 BF000000 3F000000 3E800000 3F400000 3F800000 00008000 00008000 00014000 00002000 FFFFC000 8040C0FF
05400011 00000502 BF800000 C0700000 3DCCCCCD BDCCCCCD 42C80000 3FC00000 3F19999A 3DCCCCCD 3F7F0000 00000000 FFFC4000 00000CCC FFFFF334 00320000 0000C000 9919FF00
05400012 00000503 C2C80000 501502F9 46800000 47800000 C7800000 47000000 40000000 42C80000 BF000000 BDCCCCCD 7FFFFFFF 20000000 7FFFFFFF 80000000 40000000 FFFFFFFF
05400013 00000504 00000000 00000000 00000000 80000000 00000001 807FFFFF 00000000 00000001 80000000 358637BD 00000000 00000000 00000000 00000000 00000000 00000000
05400014 00000505 3E800000 3DCCCCCD 40400000 C0200000 3F000000 BF800000 3B800000 3B000000 3F7FFFFF 3F800000 00001999 00018000 FFFEC000 00004000 FFFF8000 0100FFFF
05C00015 00000506 7F800000 FF800000 358637BD 3F400000 C2C80000 3E800000 7F800000 FF800000 7FC00000 3E800000 80000000 00000000 00006000 FFCE0000 00002000 FFFFFF40

/* tests/tb_attribute_f2x.sv */
/*
 * Testbench for the attribute conversion stage
 * Plays vectors from the data file with random idle gaps and checks
 * every converted fragment two cycles after it entered
 */
`include "attr_conv_params.svh"

module tb_attribute_f2x;

    localparam int WORDS   = 18;
    localparam int NVEC    = 33;
    localparam int TIMEOUT = NVEC * 5 + 10 + 20;

    logic aclk;
    logic reset;
    logic valid;
    logic last;
    logic keep;
    fragment_pkg::screen_pos_t spx;
    fragment_pkg::screen_pos_t spy;
    logic [`ATTR_INDEX_WIDTH-1:0] index;
    logic [31:0] depth_w;
    logic [31:0] depth_z;
    logic [31:0] texture_s;
    logic [31:0] texture_t;
    logic [31:0] mipmap_s;
    logic [31:0] mipmap_t;
    logic [31:0] color_r;
    logic [31:0] color_g;
    logic [31:0] color_b;
    logic [31:0] color_a;

    logic out_valid;
    logic out_last;
    logic out_keep;
    fragment_pkg::screen_pos_t out_spx;
    fragment_pkg::screen_pos_t out_spy;
    logic [`ATTR_INDEX_WIDTH-1:0] out_index;
    logic [31:0] out_depth_w;
    fragment_pkg::fixed_t out_depth_z;
    fragment_pkg::fixed_t out_texture_s;
    fragment_pkg::fixed_t out_texture_t;
    fragment_pkg::fixed_t out_mipmap_s;
    fragment_pkg::fixed_t out_mipmap_t;
    fragment_pkg::color_t out_color_r;
    fragment_pkg::color_t out_color_g;
    fragment_pkg::color_t out_color_b;
    fragment_pkg::color_t out_color_a;

    logic [31:0] vectors [NVEC * WORDS];
    int vec_q[$];
    int sent_q[$];
    int cycle;
    int errors;
    int test_start_errors;
    int checked;
    int tests_passed;
    int tests_failed;
    integer seed;

    attribute_f2x_converter #(.ENABLE_LOD_CALC(1)) i_dut (
        .aclk(aclk), .reset(reset),
        .valid(valid), .last(last), .keep(keep),
        .spx(spx), .spy(spy), .index(index), .depth_w(depth_w),
        .depth_z(depth_z), .texture_s(texture_s), .texture_t(texture_t),
        .mipmap_s(mipmap_s), .mipmap_t(mipmap_t),
        .color_r(color_r), .color_g(color_g), .color_b(color_b), .color_a(color_a),
        .out_valid(out_valid), .out_last(out_last), .out_keep(out_keep),
        .out_spx(out_spx), .out_spy(out_spy), .out_index(out_index),
        .out_depth_w(out_depth_w), .out_depth_z(out_depth_z),
        .out_texture_s(out_texture_s), .out_texture_t(out_texture_t),
        .out_mipmap_s(out_mipmap_s), .out_mipmap_t(out_mipmap_t),
        .out_color_r(out_color_r), .out_color_g(out_color_g),
        .out_color_b(out_color_b), .out_color_a(out_color_a)
    );

    always #2 aclk = ~aclk;

    // Word w of vector v in data file column order
    function automatic logic [31:0] word_at(input int v, input int w);
        return vectors[v * WORDS + w];
    endfunction

    function automatic bit ends_test(input int v);
        logic [31:0] this_hdr;
        logic [31:0] next_hdr;
        if (v == NVEC - 1)
        begin
            return 1'b1;
        end
        this_hdr = word_at(v, 0);
        next_hdr = word_at(v + 1, 0);
        return next_hdr[31:24] != this_hdr[31:24];
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v, input int v);
        if (act_v !== exp_v)
        begin
            $display("Fail %s expected %h actual %h (vector %0d)", name, exp_v, act_v, v);
            errors++;
        end
    endtask

    task automatic compare_fragment(input int v);
        logic [31:0] hdr;
        logic [31:0] rgba;
        hdr = word_at(v, 0);
        rgba = word_at(v, 17);
        compare_field("out_last", 32'(hdr[23]), 32'(out_last), v);
        compare_field("out_keep", 32'(hdr[22]), 32'(out_keep), v);
        compare_field("out_spx", 32'(hdr[21:11]), 32'(out_spx), v);
        compare_field("out_spy", 32'(hdr[10:0]), 32'(out_spy), v);
        compare_field("out_index", word_at(v, 1), out_index, v);
        compare_field("out_depth_w", word_at(v, 2), out_depth_w, v);
        compare_field("out_depth_z", word_at(v, 12), out_depth_z, v);
        compare_field("out_texture_s", word_at(v, 13), out_texture_s, v);
        compare_field("out_texture_t", word_at(v, 14), out_texture_t, v);
        compare_field("out_mipmap_s", word_at(v, 15), out_mipmap_s, v);
        compare_field("out_mipmap_t", word_at(v, 16), out_mipmap_t, v);
        compare_field("out_color_r", 32'(rgba[31:24]), 32'(out_color_r), v);
        compare_field("out_color_g", 32'(rgba[23:16]), 32'(out_color_g), v);
        compare_field("out_color_b", 32'(rgba[15:8]), 32'(out_color_b), v);
        compare_field("out_color_a", 32'(rgba[7:0]), 32'(out_color_a), v);
    endtask

    task automatic finish_vector(input int v);
        logic [31:0] hdr;
        checked++;
        hdr = word_at(v, 0);
        if (ends_test(v))
        begin
            if (errors == test_start_errors)
            begin
                tests_passed++;
                $display("Test %0d passed", hdr[31:24]);
            end
            else
            begin
                tests_failed++;
                $display("Test %0d failed with %0d errors", hdr[31:24],
                         errors - test_start_errors);
            end
            test_start_errors = errors;
        end
    endtask

    task automatic drive_vector(input int v);
        logic [31:0] hdr;
        hdr = word_at(v, 0);
        valid     <= 1'b1;
        last      <= hdr[23];
        keep      <= hdr[22];
        spx       <= hdr[21:11];
        spy       <= hdr[10:0];
        index     <= word_at(v, 1);
        depth_w   <= word_at(v, 2);
        depth_z   <= word_at(v, 3);
        texture_s <= word_at(v, 4);
        texture_t <= word_at(v, 5);
        mipmap_s  <= word_at(v, 6);
        mipmap_t  <= word_at(v, 7);
        color_r   <= word_at(v, 8);
        color_g   <= word_at(v, 9);
        color_b   <= word_at(v, 10);
        color_a   <= word_at(v, 11);
    endtask

    // Cycle count and run limit
    always @(posedge aclk)
    begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT)
        begin
            $display("Timeout after %0d cycles, %0d of %0d vectors checked",
                     cycle, checked, NVEC);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////
    // Output monitor
    //////////////////////////////
    always @(negedge aclk)
    begin
        int v;
        int s;
        if (cycle > 0)
        begin
            if (out_valid === 1'b1)
            begin
                if (vec_q.size() == 0)
                begin
                    $display("out_valid high at cycle %0d with no fragment in flight", cycle);
                    errors++;
                end
                else
                begin
                    v = vec_q.pop_front();
                    s = sent_q.pop_front();
                    if (cycle != s + 2)
                    begin
                        $display("Vector %0d came out at cycle %0d instead of cycle %0d",
                                 v, cycle, s + 2);
                        errors++;
                    end
                    compare_fragment(v);
                    finish_vector(v);
                end
            end
            else
            begin
                if (out_valid !== 1'b0)
                begin
                    $display("out_valid is unknown at cycle %0d", cycle);
                    errors++;
                end
                if (checked == 0 && out_last !== 1'b0)
                begin
                    $display("out_last is not low before the first fragment, cycle %0d", cycle);
                    errors++;
                end
                if (sent_q.size() > 0 && cycle > sent_q[0] + 2)
                begin
                    v = vec_q.pop_front();
                    s = sent_q.pop_front();
                    $display("Vector %0d sent at cycle %0d never came out", v, s);
                    errors++;
                    finish_vector(v);
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial
    begin
        int gap;
        aclk = 1'b0;
        reset = 1'b1;
        valid = 1'b0;
        last = 1'b0;
        keep = 1'b0;
        spx = '0;
        spy = '0;
        index = '0;
        depth_w = '0;
        depth_z = '0;
        texture_s = '0;
        texture_t = '0;
        mipmap_s = '0;
        mipmap_t = '0;
        color_r = '0;
        color_g = '0;
        color_b = '0;
        color_a = '0;
        cycle = 0;
        errors = 0;
        test_start_errors = 0;
        checked = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed = 57;
        $readmemh("tests/attribute_testdata.hex", vectors);

        repeat (10) @(posedge aclk);
        reset <= 1'b0;
        // Idle cycles so the outputs are seen low after reset
        repeat (3) @(posedge aclk);

        for (int v = 0; v < NVEC; v++)
        begin
            @(posedge aclk);
            drive_vector(v);
            vec_q.push_back(v);
            // Cycle the fragment occupies on the inputs
            sent_q.push_back(cycle + 1);
            gap = {$random(seed)} % 4;
            repeat (gap)
            begin
                @(posedge aclk);
                valid <= 1'b0;
            end
        end
        @(posedge aclk);
        valid <= 1'b0;

        wait (checked == NVEC);
        // A few more cycles to catch stray strobes
        repeat (4) @(posedge aclk);

        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
